// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [15:0] word_t;     // data word
  typedef logic [9:0]  addr_t;     // physical ram address
  typedef logic [3:0]  page_t;     // physical page index
  typedef logic [2:0]  reg_idx_t;  // register number

  localparam int page_bits = 6;    // 64 words per page
  localparam int num_regs  = 8;

  // process block layout
  localparam addr_t blk_next   = 10'd0;  // base of next block
  localparam addr_t blk_pc     = 10'd1;
  localparam addr_t blk_state  = 10'd2;  // nonzero once exited
  localparam addr_t blk_regs   = 10'd3;  // eight register words
  localparam word_t prog_start = 16'd16; // first instruction, logical

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17
  } opcode_t;

  typedef enum logic [2:0] {
    cs_fetch_op,   // first instruction word
    cs_fetch_val,  // second instruction word
    cs_exec,
    cs_mem,        // ram2reg or reg2ram access
    cs_switch,     // waiting on the task switcher
    cs_stop
  } core_state_t;

  typedef enum logic [2:0] {
    sw_idle,
    sw_save,       // pc and registers out
    sw_mark,       // blk_state write on exit
    sw_rd_next,
    sw_rd_state,
    sw_restore,    // pc and registers in
    sw_done,
    sw_halt
  } switch_state_t;

endpackage

// ==== logic/mem_if.sv ====
`timescale 1ns/1ps

interface mem_if;
  import cpu_pkg::*;

  logic  req_valid;  // one cycle, spends the credit
  logic  req_write;
  addr_t req_addr;
  word_t req_wdata;
  logic  rsp_valid;  // one per request, writes too
  word_t rsp_data;
  logic  credit;     // returned with rsp_valid

  modport client (output req_valid, req_write, req_addr, req_wdata,
                  input  rsp_valid, rsp_data, credit);

  modport server (input  req_valid, req_write, req_addr, req_wdata,
                  output rsp_valid, rsp_data, credit);

endinterface

// ==== logic/ram_port.sv ====
`timescale 1ns/1ps

module ram_port (
  input  logic           clka,
  input  logic           rst,
  input  logic           host_valid,
  input  logic           host_write,
  input  cpu_pkg::addr_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  output logic           host_credit,
  output logic           host_rsp_valid,
  output cpu_pkg::word_t host_rsp_data,
  mem_if.server          mmu,
  mem_if.server          sw
);
  import cpu_pkg::*;

  localparam int n_cl = 3;  // 0 host, 1 mmu, 2 switcher, by priority

  word_t           ram [1 << $bits(addr_t)];
  logic [n_cl-1:0] in_valid;
  logic [n_cl-1:0] in_write;
  addr_t           in_addr [n_cl];
  word_t           in_wdata [n_cl];
  logic [n_cl-1:0] pend_valid;
  logic [n_cl-1:0] pend_write;
  addr_t           pend_addr [n_cl];
  word_t           pend_wdata [n_cl];
  logic [n_cl-1:0] grant;
  logic            g_write;
  addr_t           g_addr;
  word_t           g_wdata;
  logic [n_cl-1:0] rsp_q;
  word_t           rsp_data_q;

  assign in_valid    = {sw.req_valid, mmu.req_valid, host_valid};
  assign in_write    = {sw.req_write, mmu.req_write, host_write};
  assign in_addr[0]  = host_addr;
  assign in_addr[1]  = mmu.req_addr;
  assign in_addr[2]  = sw.req_addr;
  assign in_wdata[0] = host_wdata;
  assign in_wdata[1] = mmu.req_wdata;
  assign in_wdata[2] = sw.req_wdata;

  // held request first, else the one arriving now
  always_comb begin
    grant   = '0;
    g_write = 1'b0;
    g_addr  = '0;
    g_wdata = '0;
    for (int i = n_cl - 1; i >= 0; i--) begin
      if (pend_valid[i] || in_valid[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        g_write  = pend_valid[i] ? pend_write[i] : in_write[i];
        g_addr   = pend_valid[i] ? pend_addr[i]  : in_addr[i];
        g_wdata  = pend_valid[i] ? pend_wdata[i] : in_wdata[i];
      end
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      pend_valid <= '0;
      rsp_q      <= '0;
    end else begin
      rsp_q <= grant;
      for (int i = 0; i < n_cl; i++) begin
        if (grant[i]) pend_valid[i] <= 1'b0;
        else if (in_valid[i]) pend_valid[i] <= 1'b1;  // lost arbitration
      end
    end
  end

  always_ff @(posedge clka) begin
    for (int i = 0; i < n_cl; i++) begin
      if (in_valid[i] && !grant[i]) begin
        pend_write[i] <= in_write[i];
        pend_addr[i]  <= in_addr[i];
        pend_wdata[i] <= in_wdata[i];
      end
    end
  end

  always_ff @(posedge clka) begin
    if (|grant) begin
      if (g_write) ram[g_addr] <= g_wdata;
      rsp_data_q <= ram[g_addr];  // old word on writes
    end
  end

  assign host_rsp_valid = rsp_q[0];
  assign host_credit    = rsp_q[0];
  assign host_rsp_data  = rsp_data_q;
  assign mmu.rsp_valid  = rsp_q[1];
  assign mmu.credit     = rsp_q[1];
  assign mmu.rsp_data   = rsp_data_q;
  assign sw.rsp_valid   = rsp_q[2];
  assign sw.credit      = rsp_q[2];
  assign sw.rsp_data    = rsp_data_q;

  for (genvar g = 0; g < n_cl; g++) begin : g_one_pending
    a_one_pending: assert property (@(posedge clka) disable iff (!rst)
      !(pend_valid[g] && in_valid[g]));
  end

endmodule

// ==== logic/page_mmu.sv ====
`timescale 1ns/1ps

module page_mmu #(
  parameter int init_pages = 2
) (
  input  logic           clka,
  input  logic           rst,
  mem_if.server          core_side,
  mem_if.client          ram_side,
  input  cpu_pkg::addr_t blk_base
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {m_idle, m_walk, m_issue, m_wait} mmu_state_t;

  localparam int n_pages = 1 << $bits(page_t);

  mmu_state_t         state;
  page_t              chain_next [n_pages];
  page_t              lpage [n_pages];       // logical page held by each physical page
  logic [n_pages-1:0] used;
  logic [n_pages-1:0] has_next;
  logic               ram_credit;
  addr_t              lat_addr;
  logic               lat_write;
  word_t              lat_wdata;
  page_t              cur;
  page_t              phys;
  page_t              base_pg;
  page_t              lp_in;
  page_t              lp_lat;
  page_t              free_pg;
  logic               free_any;
  logic               cache_vld;
  page_t              cache_base;
  page_t              cache_lp;
  page_t              cache_pp;
  logic               hit;

  assign base_pg = page_t'(blk_base >> page_bits);
  assign lp_in   = page_t'(core_side.req_addr >> page_bits);
  assign lp_lat  = page_t'(lat_addr >> page_bits);
  assign hit     = cache_vld && cache_base == base_pg && cache_lp == lp_in;

  // lowest numbered free page
  always_comb begin
    free_any = 1'b0;
    free_pg  = '0;
    for (int i = n_pages - 1; i >= 0; i--) begin
      if (!used[i]) begin
        free_any = 1'b1;
        free_pg  = page_t'(i);
      end
    end
  end

  assign ram_side.req_valid = (state == m_issue) && ram_credit;
  assign ram_side.req_write = lat_write;
  assign ram_side.req_addr  = addr_t'({phys, lat_addr[page_bits-1:0]});
  assign ram_side.req_wdata = lat_wdata;

  assign core_side.rsp_valid = (state == m_wait) && ram_side.rsp_valid;
  assign core_side.rsp_data  = ram_side.rsp_data;
  assign core_side.credit    = core_side.rsp_valid;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= m_idle;
      ram_credit <= 1'b1;
      cache_vld  <= 1'b0;
      for (int i = 0; i < n_pages; i++) begin
        used[i]       <= (i < init_pages);  // process blocks, logical page 0
        has_next[i]   <= 1'b0;
        lpage[i]      <= '0;
        chain_next[i] <= '0;
      end
    end else begin
      if (ram_side.req_valid) ram_credit <= 1'b0;
      else if (ram_side.credit) ram_credit <= 1'b1;

      case (state)
        m_idle: if (core_side.req_valid) begin
          lat_addr  <= core_side.req_addr;
          lat_write <= core_side.req_write;
          lat_wdata <= core_side.req_wdata;
          if (hit) begin
            phys  <= cache_pp;
            state <= m_issue;
          end else begin
            cur   <= base_pg;
            state <= m_walk;
          end
        end
        m_walk: begin
          if (lpage[cur] == lp_lat) begin
            phys       <= cur;
            cache_pp   <= cur;
            cache_vld  <= 1'b1;
            cache_base <= base_pg;
            cache_lp   <= lp_lat;
            state      <= m_issue;
          end else if (has_next[cur]) begin
            cur <= chain_next[cur];  // one step per cycle
          end else begin
            chain_next[cur]   <= free_pg;  // append to chain tail
            has_next[cur]     <= 1'b1;
            used[free_pg]     <= 1'b1;
            lpage[free_pg]    <= lp_lat;
            has_next[free_pg] <= 1'b0;
            phys              <= free_pg;
            cache_pp          <= free_pg;
            cache_vld         <= 1'b1;
            cache_base        <= base_pg;
            cache_lp          <= lp_lat;
            state             <= m_issue;
          end
        end
        m_issue: if (ram_side.req_valid) state <= m_wait;
        m_wait:  if (ram_side.rsp_valid) state <= m_idle;
        default: ;
      endcase
    end
  end

  a_page_free: assert property (@(posedge clka) disable iff (!rst)
    (state == m_walk && lpage[cur] != lp_lat && !has_next[cur]) |-> free_any);

endmodule

// ==== logic/task_switcher.sv ====
`timescale 1ns/1ps

module task_switcher (
  input  logic           clka,
  input  logic           rst,
  mem_if.client          mem,
  input  logic           switch_req,
  output logic           switch_done,
  input  logic           proc_exit,
  output cpu_pkg::addr_t blk_base,
  output logic [3:0]     ctx_idx,
  output logic           ctx_we,
  output cpu_pkg::word_t ctx_wdata,
  input  cpu_pkg::word_t ctx_rdata,
  output logic           halted
);
  import cpu_pkg::*;

  switch_state_t state;
  logic          have_credit;
  addr_t         cur;          // block whose next pointer is read
  addr_t         cand;         // candidate next process
  logic [3:0]    idx;          // 0..7 register, 8 pc

  function automatic addr_t slot_addr(addr_t base, logic [3:0] i);
    return (i == 4'(num_regs)) ? base + blk_pc : base + blk_regs + addr_t'(i);
  endfunction

  always_comb begin
    mem.req_write = 1'b0;
    mem.req_addr  = cur + blk_next;
    mem.req_wdata = ctx_rdata;
    case (state)
      sw_save: begin
        mem.req_write = 1'b1;
        mem.req_addr  = slot_addr(blk_base, idx);
      end
      sw_mark: begin
        mem.req_write = 1'b1;
        mem.req_addr  = blk_base + blk_state;
        mem.req_wdata = 16'd1;
      end
      sw_rd_state: mem.req_addr = cand + blk_state;
      sw_restore:  mem.req_addr = slot_addr(cand, idx);
      default: ;
    endcase
  end

  assign mem.req_valid = have_credit &&
    (state inside {sw_save, sw_mark, sw_rd_next, sw_rd_state, sw_restore});

  assign ctx_idx     = idx;
  assign ctx_we      = (state == sw_restore) && mem.rsp_valid;
  assign ctx_wdata   = mem.rsp_data;
  assign switch_done = (state == sw_done);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= sw_idle;
      have_credit <= 1'b1;
      blk_base    <= '0;  // process 0 block
      halted      <= 1'b0;
      idx         <= '0;
    end else begin
      if (mem.req_valid) have_credit <= 1'b0;
      else if (mem.credit) have_credit <= 1'b1;

      case (state)
        sw_idle: if (switch_req) begin
          idx   <= '0;
          state <= sw_save;
        end
        sw_save: if (mem.rsp_valid) begin
          if (idx == 4'(num_regs)) begin
            idx   <= '0;
            cur   <= blk_base;
            state <= proc_exit ? sw_mark : sw_rd_next;
          end else begin
            idx <= idx + 4'd1;
          end
        end
        sw_mark: if (mem.rsp_valid) state <= sw_rd_next;
        sw_rd_next: if (mem.rsp_valid) begin
          cand  <= addr_t'(mem.rsp_data);
          state <= sw_rd_state;
        end
        sw_rd_state: if (mem.rsp_valid) begin
          if (mem.rsp_data == '0) begin
            idx   <= '0;
            state <= sw_restore;
          end else if (cand == blk_base) begin
            halted <= 1'b1;  // back around, nobody left alive
            state  <= sw_halt;
          end else begin
            cur   <= cand;  // skip exited block
            state <= sw_rd_next;
          end
        end
        sw_restore: if (mem.rsp_valid) begin
          if (idx == 4'(num_regs)) begin
            blk_base <= cand;
            state    <= sw_done;
          end else begin
            idx <= idx + 4'd1;
          end
        end
        sw_done: state <= sw_idle;
        default: ;
      endcase
    end
  end

  a_done_req: assert property (@(posedge clka) disable iff (!rst)
    switch_done |-> switch_req);

endmodule

// ==== logic/exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
  parameter int slice_len = 4
) (
  input  logic           clka,
  input  logic           rst,
  input  logic           run,
  mem_if.client          mem,
  output logic           switch_req,
  input  logic           switch_done,
  input  cpu_pkg::addr_t blk_base,
  input  logic [3:0]     ctx_idx,    // 0..7 register, 8 pc
  input  logic           ctx_we,
  input  cpu_pkg::word_t ctx_wdata,
  output cpu_pkg::word_t ctx_rdata,
  output logic           proc_exit,
  input  logic           halted
);
  import cpu_pkg::*;

  core_state_t state;
  logic        have_credit;
  word_t       pc;
  opcode_t     inst_op;
  reg_idx_t    inst_reg;
  word_t       inst_val;
  word_t       regs [num_regs];
  logic [7:0]  icount;          // instructions done in this slice
  logic        slice_end;
  logic        rf_we;
  reg_idx_t    rf_idx;
  word_t       rf_wdata;

  assign slice_end  = (icount == 8'(slice_len - 1));
  assign switch_req = (state == cs_switch);
  assign ctx_rdata  = ctx_idx[3] ? pc : regs[ctx_idx[2:0]];

  always_comb begin
    mem.req_valid = 1'b0;
    mem.req_write = 1'b0;
    mem.req_addr  = addr_t'(pc);
    mem.req_wdata = regs[inst_reg];
    case (state)
      cs_fetch_op:  mem.req_valid = have_credit && run;  // run only gates new instructions
      cs_fetch_val: mem.req_valid = have_credit;
      cs_mem: begin
        mem.req_valid = have_credit;
        mem.req_write = (inst_op == op_reg2ram);
        mem.req_addr  = addr_t'(inst_val);
      end
      default: ;
    endcase
  end

  // register file write port shared by execute and context restore
  always_comb begin
    rf_we    = 1'b0;
    rf_idx   = inst_reg;
    rf_wdata = inst_val;
    if (ctx_we) begin
      rf_we    = !ctx_idx[3];
      rf_idx   = ctx_idx[2:0];
      rf_wdata = ctx_wdata;
    end else if (state == cs_exec) begin
      case (inst_op)
        op_num2reg:   rf_we = 1'b1;
        op_reg_plus: begin
          rf_we    = 1'b1;
          rf_wdata = regs[inst_reg] + inst_val;  // wraps at 16 bits
        end
        op_reg_minus: begin
          rf_we    = 1'b1;
          rf_wdata = regs[inst_reg] - inst_val;
        end
        default: ;
      endcase
    end else if (state == cs_mem && mem.rsp_valid && inst_op == op_ram2reg) begin
      rf_we    = 1'b1;
      rf_wdata = mem.rsp_data;
    end
  end

  always_ff @(posedge clka) begin
    if (rf_we) regs[rf_idx] <= rf_wdata;
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= cs_fetch_op;
      have_credit <= 1'b1;
      pc          <= prog_start;
      icount      <= '0;
      proc_exit   <= 1'b0;
    end else begin
      if (mem.req_valid) have_credit <= 1'b0;
      else if (mem.credit) have_credit <= 1'b1;

      case (state)
        cs_fetch_op: if (mem.rsp_valid) begin
          inst_op  <= opcode_t'(mem.rsp_data[15:8]);
          inst_reg <= reg_idx_t'(mem.rsp_data[2:0]);  // register in the low byte
          pc       <= pc + 16'd1;
          state    <= cs_fetch_val;
        end
        cs_fetch_val: if (mem.rsp_valid) begin
          inst_val <= mem.rsp_data;
          pc       <= pc + 16'd1;
          state    <= cs_exec;
        end
        cs_exec: begin
          if (inst_op == op_jmp) pc <= inst_val;
          if (inst_op == op_exit) proc_exit <= 1'b1;
          if (inst_op == op_ram2reg || inst_op == op_reg2ram) begin
            state <= cs_mem;
          end else if (inst_op == op_exit || slice_end) begin
            state <= cs_switch;
          end else begin
            icount <= icount + 8'd1;
            state  <= cs_fetch_op;
          end
        end
        cs_mem: if (mem.rsp_valid) begin
          if (slice_end) begin
            state <= cs_switch;
          end else begin
            icount <= icount + 8'd1;
            state  <= cs_fetch_op;
          end
        end
        cs_switch: begin
          if (ctx_we && ctx_idx[3]) pc <= ctx_wdata;  // restored pc
          if (halted) begin
            state <= cs_stop;
          end else if (switch_done) begin
            icount    <= '0;
            proc_exit <= 1'b0;
            state     <= cs_fetch_op;
          end
        end
        default: ;
      endcase
    end
  end

  // a credit only comes back for a request already spent
  a_credit_spent: assert property (@(posedge clka) disable iff (!rst)
    mem.credit |-> !have_credit);

  // block base only moves under a switch handshake
  a_base_stable: assert property (@(posedge clka) disable iff (!rst)
    !$stable(blk_base) |-> $past(switch_req));

endmodule

// ==== logic/task_cpu.sv ====
`timescale 1ns/1ps

module task_cpu #(
  parameter int slice_len  = 4,
  parameter int init_pages = 2
) (
  input  logic           clka,
  input  logic           rst,
  input  logic           run,
  input  logic           host_valid,
  input  logic           host_write,
  input  cpu_pkg::addr_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  output logic           host_credit,
  output logic           host_rsp_valid,
  output cpu_pkg::word_t host_rsp_data,
  output logic           halted
);
  import cpu_pkg::*;

  mem_if core_mmu ();  // logical addresses
  mem_if mmu_ram ();   // physical addresses
  mem_if sw_ram ();

  addr_t      blk_base;
  logic       switch_req;
  logic       switch_done;
  logic       proc_exit;
  logic [3:0] ctx_idx;
  logic       ctx_we;
  word_t      ctx_wdata;
  word_t      ctx_rdata;

  exec_core #(.slice_len(slice_len)) i_exec_core (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .mem        (core_mmu.client),
    .switch_req (switch_req),
    .switch_done(switch_done),
    .blk_base   (blk_base),
    .ctx_idx    (ctx_idx),
    .ctx_we     (ctx_we),
    .ctx_wdata  (ctx_wdata),
    .ctx_rdata  (ctx_rdata),
    .proc_exit  (proc_exit),
    .halted     (halted)
  );

  page_mmu #(.init_pages(init_pages)) i_page_mmu (
    .clka     (clka),
    .rst      (rst),
    .core_side(core_mmu.server),
    .ram_side (mmu_ram.client),
    .blk_base (blk_base)
  );

  task_switcher i_task_switcher (
    .clka       (clka),
    .rst        (rst),
    .mem        (sw_ram.client),
    .switch_req (switch_req),
    .switch_done(switch_done),
    .proc_exit  (proc_exit),
    .blk_base   (blk_base),
    .ctx_idx    (ctx_idx),
    .ctx_we     (ctx_we),
    .ctx_wdata  (ctx_wdata),
    .ctx_rdata  (ctx_rdata),
    .halted     (halted)
  );

  ram_port i_ram_port (
    .clka          (clka),
    .rst           (rst),
    .host_valid    (host_valid),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_credit   (host_credit),
    .host_rsp_valid(host_rsp_valid),
    .host_rsp_data (host_rsp_data),
    .mmu           (mmu_ram.server),
    .sw            (sw_ram.server)
  );

endmodule

// ==== tb/tb_task_cpu.sv ====
`timescale 1ns/1ps

module tb_task_cpu;
  import cpu_pkg::*;

  localparam int    slice_len  = 4;
  localparam int    init_pages = 2;
  localparam int    wait_limit = 200;    // cycles per host handshake
  localparam int    halt_limit = 20000;
  localparam addr_t blk1       = 10'd64; // process 1 block in page 1

  logic  clka;
  logic  rst;
  logic  run;
  logic  host_valid;
  logic  host_write;
  addr_t host_addr;
  word_t host_wdata;
  logic  host_credit;
  logic  host_rsp_valid;
  word_t host_rsp_data;
  logic  halted;

  int         seed = 46159;
  int         errors;
  int         timeouts;
  int         exit_count;
  logic       exit_q;
  logic       host_cred;    // one after reset
  word_t      imm_a [2];
  word_t      imm_b [2];
  word_t      imm_c [2];
  word_t      imm_x [2];
  word_t      pre [2];      // host preloaded word at logical 44
  logic [5:0] pg_off [2];   // offset of the logical page 1 store

  task_cpu #(.slice_len(slice_len), .init_pages(init_pages)) i_task_cpu (
    .clka          (clka),
    .rst           (rst),
    .run           (run),
    .host_valid    (host_valid),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_credit   (host_credit),
    .host_rsp_valid(host_rsp_valid),
    .host_rsp_data (host_rsp_data),
    .halted        (halted)
  );

  always #20 clka = ~clka;

  // counts rising edges of proc_exit
  always @(posedge clka) begin
    if (!rst) begin
      exit_q     <= 1'b0;
      exit_count <= 0;
    end else begin
      exit_q <= i_task_cpu.proc_exit;
      if (i_task_cpu.proc_exit && !exit_q) exit_count <= exit_count + 1;
    end
  end

  a_halt_after_exits: assert property (@(posedge clka) disable iff (!rst)
    $rose(halted) |-> exit_count == 2)
    else begin
      $display("halted rose at %0t after only %0d exits", $time, exit_count);
      errors++;
    end

  a_rsp_credit: assert property (@(posedge clka) disable iff (!rst)
    host_rsp_valid |-> host_credit && !host_cred)
    else begin
      $display("host response at %0t without an outstanding request", $time);
      errors++;
    end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp)
      else begin
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
      end
  endtask

  task automatic host_access(input logic wr, input addr_t addr, input word_t wdata,
                             output word_t rdata);
    int  n;
    logic got;
    n     = 0;
    got   = 1'b0;
    rdata = '0;
    @(posedge clka);
    while (!host_cred && n < wait_limit) begin
      @(posedge clka);
      if (host_credit) host_cred = 1'b1;
      n++;
    end
    if (!host_cred) begin
      $display("timeout at %0t waiting for a host credit", $time);
      timeouts++;
    end
    host_valid <= 1'b1;
    host_write <= wr;
    host_addr  <= addr;
    host_wdata <= wdata;
    host_cred = 1'b0;  // spent
    @(posedge clka);
    host_valid <= 1'b0;
    n = 0;
    while (!got && n < wait_limit) begin
      @(posedge clka);
      n++;
      if (host_rsp_valid) begin
        got   = 1'b1;
        rdata = host_rsp_data;
        if (host_credit) host_cred = 1'b1;
      end
    end
    if (!got) begin
      $display("timeout at %0t waiting for the host response from %h", $time, addr);
      timeouts++;
      host_cred = 1'b1;
    end
  endtask

  task automatic write_word(input addr_t addr, input word_t data);
    word_t old;
    host_access(1'b1, addr, data, old);
  endtask

  task automatic expect_word(input string name, input addr_t addr, input word_t exp);
    word_t got;
    host_access(1'b0, addr, '0, got);
    check_word(name, got, exp);
  endtask

  task automatic load_instr(input addr_t base, input int idx, input opcode_t op,
                            input reg_idx_t r, input word_t val);
    addr_t a;
    a = base + addr_t'(prog_start) + addr_t'(2 * idx);
    write_word(a, {op, 8'(r)});  // opcode in the high byte
    write_word(a + 10'd1, val);
  endtask

  task automatic load_process(input int p, input addr_t base, input addr_t next);
    write_word(base + blk_next, word_t'(next));
    write_word(base + blk_pc, prog_start);
    write_word(base + blk_state, 16'd0);
    for (int r = 0; r < num_regs; r++) write_word(base + blk_regs + addr_t'(r), 16'd0);
    load_instr(base, 0, op_num2reg, 3'd1, imm_a[p]);
    load_instr(base, 1, op_reg_plus, 3'd1, imm_b[p]);
    load_instr(base, 2, op_reg_minus, 3'd1, imm_c[p]);
    load_instr(base, 3, op_reg2ram, 3'd1, 16'd40);
    load_instr(base, 4, op_num2reg, 3'd2, imm_x[p]);
    load_instr(base, 5, op_jmp, 3'd0, prog_start + 16'd14);  // lands on instruction 7
    load_instr(base, 6, op_num2reg, 3'd2, ~imm_x[p]);        // never executed
    load_instr(base, 7, op_reg2ram, 3'd2, 16'd41);
    load_instr(base, 8, op_ram2reg, 3'd3, 16'd44);
    load_instr(base, 9, op_reg2ram, 3'd3, 16'd42);
    load_instr(base, 10, op_reg2ram, 3'd1, 16'd64 + 16'(pg_off[p]));
    load_instr(base, 11, op_exit, 3'd0, 16'd0);
    write_word(base + 10'd44, pre[p]);
  endtask

  initial begin
    int    n;
    word_t val;
    word_t got;
    addr_t base;
    clka       = 1'b0;
    rst        = 1'b0;
    run        = 1'b0;
    host_valid = 1'b0;
    host_write = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_cred  = 1'b1;
    errors     = 0;
    timeouts   = 0;
    for (int p = 0; p < 2; p++) begin
      imm_a[p]  = word_t'($random(seed));
      imm_b[p]  = word_t'($random(seed));
      imm_c[p]  = word_t'($random(seed));
      imm_x[p]  = word_t'($random(seed));
      pre[p]    = word_t'($random(seed));
      pg_off[p] = 6'($random(seed));
    end

    repeat (3) @(posedge clka);
    rst <= 1'b1;
    @(posedge clka);
    check_word("halted", {15'd0, halted}, 16'd0);
    check_word("host_rsp_valid", {15'd0, host_rsp_valid}, 16'd0);
    check_word("host_credit", {15'd0, host_credit}, 16'd0);

    // plain host round trip with the core idle
    val = word_t'($random(seed));
    write_word(10'd900, val);
    expect_word("host_rsp_data", 10'd900, val);

    load_process(0, 10'd0, blk1);  // circular next pointers
    load_process(1, blk1, 10'd0);

    @(posedge clka);
    run <= 1'b1;
    expect_word("host_rsp_data", 10'd44, pre[0]);  // served while running

    n = 0;
    while (!halted && n < halt_limit) begin
      @(posedge clka);
      n++;
    end
    if (!halted) begin
      $display("timeout: halted did not rise within %0d cycles", halt_limit);
      timeouts++;
    end

    for (int p = 0; p < 2; p++) begin
      base = (p == 0) ? 10'd0 : blk1;
      expect_word("reg_plus/reg_minus result", base + 10'd40,
                  word_t'(imm_a[p] + imm_b[p] - imm_c[p]));
      expect_word("num2reg before jmp", base + 10'd41, imm_x[p]);
      expect_word("ram2reg copy", base + 10'd42, pre[p]);
      expect_word("page 1 store", addr_t'((init_pages + p) << page_bits) + addr_t'(pg_off[p]),
                  word_t'(imm_a[p] + imm_b[p] - imm_c[p]));
      host_access(1'b0, base + blk_state, '0, got);
      assert (got != 16'd0)
        else begin
          $display("** Error at %0t: blk_state expected nonzero got %h", $time, got);
          errors++;
        end
    end

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== task_cpu.f ====
logic/cpu_pkg.sv
logic/mem_if.sv
logic/ram_port.sv
logic/page_mmu.sv
logic/task_switcher.sv
logic/exec_core.sv
logic/task_cpu.sv
tb/tb_task_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_task_cpu -Mdir obj_dir -f task_cpu.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_task_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
